/* rw_engine_tests.txt */
# All values hex. C const_mask const_value ops_mask granularity direction array_pointer command
# D gap_ok f0 f1 f2 f3 | E command address f0 f1 f2 f3 | W cycles | X clear | T test_name
C 0 00000000 1248 0 1 10000000 1
W 2
D 0 11111111 22222222 33333333 44444444
E 1 43333333 44444444 33333333 22222222 11111111
T route_write
C 2 00001000 8421 4 0 20000000 1
W 2
D 0 aaaa0000 deadbeef 12345678 0badf00d
D 1 00000001 ffffffff 00000002 00000003
E 1 20000100 aaaa0000 deadbeef 12345678 0badf00d
E 1 20000100 00000001 ffffffff 00000002 00000003
T const_shift_right
C 0 00000000 0012 8 1 f0000000 0
W 2
D 0 12345678 00abcdef 55555555 66666666
E 0 24567800 00000000 00000000 00000000 00000000
T read_shift_left
C 0 00000000 8421 2 1 00001000 1
W 2
D 0 a0000000 00000001 a2000000 a3000000
D 0 b0000000 00000010 b2000000 b3000000
D 0 c0000000 00000100 c2000000 c3000000
E 1 00001004 a0000000 00000001 a2000000 a3000000
E 1 00001040 b0000000 00000010 b2000000 b3000000
E 1 00001400 c0000000 00000100 c2000000 c3000000
T back_to_back
D 0 d0000000 00000005 d2000000 d3000000
D 0 e0000000 00000006 e2000000 e3000000
C 0 00000000 8421 0 1 00008000 1
D 0 f0000000 00000007 f2000000 f3000000
W 4
D 0 01000000 00000009 02000000 03000000
E 1 00001014 d0000000 00000005 d2000000 d3000000
E 1 00001018 e0000000 00000006 e2000000 e3000000
E 1 0000101c f0000000 00000007 f2000000 f3000000
E 1 00008009 01000000 00000009 02000000 03000000
T deferred_config
D 0 11110000 00000001 22220000 33330000
X
D 0 44440000 00000002 55550000 66660000
W 1
C 0 00000000 8421 0 1 00009000 1
W 2
D 0 77770000 00000003 88880000 99990000
E 1 00009003 77770000 00000003 88880000 99990000
T clear_drop

/* src.f */
rw_engine_pkg.sv
rw_config_regs.sv
rw_field_select_kernel.sv
rw_request_builder.sv
rw_engine_top.sv
tb_rw_checker.sv
tb_rw_engine.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_rw_engine
FILELIST    ?= src.f
OBJ_DIR     ?= obj_dir
PASS_MSG    ?= Test completed successfully
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the simulation output holds the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_rw_engine.sv */
// Testbench top with clock and reset, data file loading, stimulus with LFSR gaps and watchdog

`timescale 1ns/100ps

module tb_rw_engine import rw_engine_pkg::*; ();

  localparam int    CLK_PERIOD = 4;
  localparam int    MAX_REC    = 256;
  localparam string TEST_FILE  = "rw_engine_tests.txt";

  logic         ap_clk = 1'b0;
  logic         areset;
  logic         clear;
  logic         cfg_write;
  logic         data_valid;
  rw_config_t   cfg_in;
  packet_t      data_in;
  logic         req_valid;
  mem_request_t req_out;
  logic         cfg_active;

  byte          rec_kind [MAX_REC];
  logic [31:0]  rec_val  [MAX_REC][7];
  string        rec_name [MAX_REC];
  int           num_rec = 0;
  logic [15:0]  lfsr_state = 16'd26;

  always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

  rw_engine_top u_dut (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .clear      (clear),
    .cfg_write  (cfg_write),
    .cfg_in     (cfg_in),
    .data_valid (data_valid),
    .data_in    (data_in),
    .req_valid  (req_valid),
    .req_out    (req_out),
    .cfg_active (cfg_active)
  );

  tb_rw_checker u_checker (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .clear      (clear),
    .data_valid (data_valid),
    .cfg_active (cfg_active),
    .req_valid  (req_valid),
    .req_out    (req_out)
  );

  // Hex values that follow each record letter
  function automatic int value_count(input byte kind);
    case (kind)
      "C": return 7;
      "D": return 5;
      "E": return 6;
      "W": return 1;
      "X", "T": return 0;
      default: return -1;
    endcase
  endfunction

  // All records are read up front so the watchdog can size itself
  task automatic load_records(output bit ok);
    int          fd;
    int          got;
    string       kind;
    string       text;
    logic [31:0] v;
    ok = 1'b1;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the data file %s", TEST_FILE);
      ok = 1'b0;
    end else begin
      while (ok && num_rec < MAX_REC && $fscanf(fd, " %s", kind) == 1) begin
        if (kind[0] == "#") begin
          void'($fgets(text, fd));
        end else if (value_count(kind[0]) < 0) begin
          $display("Unknown record kind %s in the data file", kind);
          ok = 1'b0;
        end else begin
          rec_kind[num_rec] = kind[0];
          for (int i = 0; i < value_count(kind[0]); i++) begin
            got = $fscanf(fd, " %h", v);
            rec_val[num_rec][i] = v;
            ok = ok && (got == 1);
          end
          if (kind[0] == "T") begin
            got = $fscanf(fd, " %s", text);
            rec_name[num_rec] = text;
            ok = ok && (got == 1);
          end
          num_rec++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Every E record of the test that starts at record first
  task automatic queue_expected(input int first);
    mem_request_t exp_req;
    int           r;
    r = first;
    while (r < num_rec && rec_kind[r] != "T") begin
      if (rec_kind[r] == "E") begin
        exp_req.command = rw_cmd_e'(rec_val[r][0][0]);
        exp_req.address = rec_val[r][1];
        for (int i = 0; i < NUM_FIELDS; i++) begin
          exp_req.data.field[i] = rec_val[r][i+2];
        end
        u_checker.expect_request(exp_req);
      end
      r++;
    end
  endtask

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic random_gap(output int gap);
    logic [1:0] bits;
    for (int k = 0; k < 2; k++) begin
      bits[k]    = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    gap = int'(bits);
  endtask

  // Strobes change a little after the rising edge and hold for one cycle
  task automatic next_cycle(input logic cw, input logic dv, input logic clr);
    @(posedge ap_clk);
    #1;
    cfg_write  = cw;
    data_valid = dv;
    clear      = clr;
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    next_cycle(1'b0, 1'b0, 1'b0);
    while (u_checker.pending_count() > 0 && waited < 8) begin
      next_cycle(1'b0, 1'b0, 1'b0);
      waited++;
    end
    // One full latency window so stray requests land in this test
    repeat (3) next_cycle(1'b0, 1'b0, 1'b0);
    u_checker.close_test(name);
  endtask

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------
  initial begin
    bit           ok;
    byte          prev_kind;
    int           gap;
    areset     = 1'b1;
    clear      = 1'b0;
    cfg_write  = 1'b0;
    data_valid = 1'b0;
    cfg_in     = '0;
    data_in    = '0;
    load_records(ok);
    repeat (10) @(posedge ap_clk);
    #1;
    areset    = 1'b0;
    prev_kind = "W";
    for (int r = 0; r < num_rec && ok; r++) begin
      // Expected requests are queued before the test drives anything
      if (r == 0 || rec_kind[r-1] == "T") begin
        queue_expected(r);
      end
      case (rec_kind[r])
        "C": begin
          next_cycle(1'b1, 1'b0, 1'b0);
          cfg_in.const_mask    = rec_val[r][0][NUM_FIELDS-1:0];
          cfg_in.const_value   = rec_val[r][1];
          cfg_in.ops_mask      = rec_val[r][2][NUM_FIELDS*NUM_FIELDS-1:0];
          cfg_in.granularity   = rec_val[r][3][SHIFT_W-1:0];
          cfg_in.direction     = rec_val[r][4][0];
          cfg_in.array_pointer = rec_val[r][5];
          cfg_in.command       = rw_cmd_e'(rec_val[r][6][0]);
        end
        "D": begin
          if (rec_val[r][0][0] && prev_kind == "D") begin
            random_gap(gap);
            repeat (gap) next_cycle(1'b0, 1'b0, 1'b0);
          end
          next_cycle(1'b0, 1'b1, 1'b0);
          for (int i = 0; i < NUM_FIELDS; i++) begin
            data_in.field[i] = rec_val[r][i+1];
          end
        end
        "X": next_cycle(1'b0, 1'b0, 1'b1);
        "W": repeat (rec_val[r][0]) next_cycle(1'b0, 1'b0, 1'b0);
        "E": ;
        default: finish_test(rec_name[r]);
      endcase
      if (rec_kind[r] != "E") begin
        prev_kind = rec_kind[r];
      end
    end
    u_checker.report_summary();
    if (ok && u_checker.error_count() == 0 && u_checker.tests_run() > 0) begin
      $display("Test completed successfully");
    end else begin
      if (!ok) begin
        $display("The data file could not be read completely");
      end
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the number of records
  initial begin
    wait (num_rec > 0);
    #((num_rec * 8 + 200) * CLK_PERIOD);
    $display("Watchdog expired before all records were run");
    $display("Test failed");
    $finish;
  end

endmodule : tb_rw_engine

/* tb_rw_checker.sv */
// Request monitor with expected-request queue, latency and value compare, per-test results

`timescale 1ns/100ps

module tb_rw_checker import rw_engine_pkg::*; (
  input logic         ap_clk,
  input logic         areset,
  input logic         clear,
  input logic         data_valid,
  input logic         cfg_active,
  input logic         req_valid,
  input mem_request_t req_out
);

  localparam int LATENCY = 3;

  mem_request_t exp_q[$];
  int           accept_q[$];
  int           cycle = 0;
  int           test_errors = 0;
  int           total_errors = 0;
  int           tests_closed = 0;
  int           tests_bad = 0;
  logic         clear_seen = 1'b0;

  task automatic expect_request(input mem_request_t req);
    exp_q.push_back(req);
  endtask

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  function automatic int error_count();
    return total_errors;
  endfunction

  function automatic int tests_run();
    return tests_closed;
  endfunction

  // --------------------------------------------------------------------
  // Compare one request against the queue head and its accept cycle
  // --------------------------------------------------------------------
  task automatic check_request();
    mem_request_t exp_req;
    int           accepted;
    if (exp_q.size() == 0) begin
      $display("Unexpected request at %0t ns, nothing was expected", $time);
      test_errors++;
    end else begin
      exp_req = exp_q.pop_front();
      if (req_out.command !== exp_req.command) begin
        $display("Fail %0t ns: command %0d, expected %0d", $time, req_out.command,
                 exp_req.command);
        test_errors++;
      end
      if (req_out.address !== exp_req.address) begin
        $display("Fail %0t ns: address %h, expected %h", $time, req_out.address,
                 exp_req.address);
        test_errors++;
      end
      for (int i = 0; i < NUM_FIELDS; i++) begin
        if (req_out.data.field[i] !== exp_req.data.field[i]) begin
          $display("Fail %0t ns: data.field[%0d] %h, expected %h", $time, i,
                   req_out.data.field[i], exp_req.data.field[i]);
          test_errors++;
        end
      end
    end
    if (accept_q.size() == 0) begin
      $display("Request at %0t ns has no accepted packet behind it", $time);
      test_errors++;
    end else begin
      accepted = accept_q.pop_front();
      if (cycle - accepted != LATENCY) begin
        $display("Fail %0t ns: latency %0d cycles, expected %0d", $time,
                 cycle - accepted, LATENCY);
        test_errors++;
      end
    end
  endtask

  // Sampled mid-cycle, away from the edge where the DUT and the stimulus change
  always @(negedge ap_clk) begin
    if (areset) begin
      cycle      = 0;
      clear_seen = 1'b0;
      accept_q.delete();
    end else begin
      cycle++;
      if (clear_seen && cfg_active) begin
        $display("cfg_active stayed high after a clear, at %0t ns", $time);
        test_errors++;
      end
      if (req_valid) begin
        check_request();
      end
      // Packets taken in with a live configuration, cleared ones never return
      if (clear) begin
        accept_q.delete();
      end else if (data_valid && cfg_active) begin
        accept_q.push_back(cycle);
      end
      clear_seen = clear;
    end
  end

  task automatic close_test(input string name);
    if (exp_q.size() != 0 || accept_q.size() != 0) begin
      $display("%0d expected request(s) and %0d accepted packet(s) never came out in %s",
               exp_q.size(), accept_q.size(), name);
      test_errors++;
      exp_q.delete();
      accept_q.delete();
    end
    tests_closed++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%-20s ok", name);
    end else begin
      $display("%-20s %0d error(s)", name, test_errors);
      tests_bad++;
    end
    test_errors = 0;
  endtask

  task automatic report_summary();
    $display("Tests run %0d, with errors %0d, total errors %0d", tests_closed, tests_bad,
             total_errors);
  endtask

endmodule : tb_rw_checker

/* rw_engine_top.sv */
// Read/write engine top joining configuration registers, kernel and request builder

`timescale 1ns/100ps

module rw_engine_top import rw_engine_pkg::*; #(
  parameter int NUM_FIELDS = rw_engine_pkg::NUM_FIELDS,
  parameter int FIELD_W    = rw_engine_pkg::FIELD_W
) (
  input  logic         ap_clk,
  input  logic         areset,
  input  logic         clear,
  input  logic         cfg_write,
  input  rw_config_t   cfg_in,
  input  logic         data_valid,
  input  packet_t      data_in,
  output logic         req_valid,
  output mem_request_t req_out,
  output logic         cfg_active
);

  rw_config_t   active_cfg;
  logic         cfg_valid;
  logic         busy;
  logic         kernel_valid;
  mem_address_t kernel_addr;
  packet_t      kernel_data;

  assign cfg_active = cfg_valid;

  rw_config_regs u_config_regs (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .clear      (clear),
    .cfg_write  (cfg_write),
    .cfg_in     (cfg_in),
    .busy       (busy),
    .active_cfg (active_cfg),
    .cfg_valid  (cfg_valid)
  );

  rw_field_select_kernel #(
    .NUM_FIELDS (NUM_FIELDS),
    .FIELD_W    (FIELD_W)
  ) u_kernel (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .clear        (clear),
    .data_valid   (data_valid),
    .data_in      (data_in),
    .active_cfg   (active_cfg),
    .cfg_valid    (cfg_valid),
    .kernel_valid (kernel_valid),
    .kernel_addr  (kernel_addr),
    .kernel_data  (kernel_data),
    .busy         (busy)
  );

  rw_request_builder u_request_builder (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .clear        (clear),
    .kernel_valid (kernel_valid),
    .kernel_addr  (kernel_addr),
    .kernel_data  (kernel_data),
    .active_cfg   (active_cfg),
    .req_valid    (req_valid),
    .req_out      (req_out)
  );

endmodule : rw_engine_top

/* rw_request_builder.sv */
// Byte address adder and registered memory request output

`timescale 1ns/100ps

module rw_request_builder import rw_engine_pkg::*; (
  input  logic         ap_clk,
  input  logic         areset,
  input  logic         clear,
  input  logic         kernel_valid,
  input  mem_address_t kernel_addr,
  input  packet_t      kernel_data,
  input  rw_config_t   active_cfg,
  output logic         req_valid,
  output mem_request_t req_out
);

  addr_t   byte_address;
  packet_t req_data;

  // --------------------------------------------------------------------
  // Request fields
  // --------------------------------------------------------------------

  // Wraps at 2**ADDR_W
  assign byte_address = kernel_addr.base + kernel_addr.offset;

  // Reads carry no payload
  always_comb begin
    if (active_cfg.command == CMD_WRITE) begin
      req_data = kernel_data;
    end else begin
      req_data = '0;
    end
  end

  // --------------------------------------------------------------------
  // Output registers
  // --------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= kernel_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (kernel_valid) begin
      req_out.command <= active_cfg.command;
      req_out.address <= byte_address;
      req_out.data    <= req_data;
    end
  end

  // Back-to-back requests need back-to-back kernel items one cycle earlier
  assert property (@(posedge ap_clk) disable iff (areset)
    (req_valid && $past(req_valid)) |-> ($past(kernel_valid, 1) && $past(kernel_valid, 2)))
    else $error("req_valid burst without matching kernel_valid");

endmodule : rw_request_builder

/* rw_field_select_kernel.sv */
// Two-stage field routing, constant substitution and offset shift pipeline

`timescale 1ns/100ps

module rw_field_select_kernel import rw_engine_pkg::*; #(
  parameter int NUM_FIELDS = rw_engine_pkg::NUM_FIELDS,
  parameter int FIELD_W    = rw_engine_pkg::FIELD_W
) (
  input  logic         ap_clk,
  input  logic         areset,
  input  logic         clear,
  input  logic         data_valid,
  input  packet_t      data_in,
  input  rw_config_t   active_cfg,
  input  logic         cfg_valid,
  output logic         kernel_valid,
  output mem_address_t kernel_addr,
  output packet_t      kernel_data,
  output logic         busy
);

  // OR mux over a one-hot row, an empty row gives zero
  function automatic field_t route_field(packet_t pkt, logic [NUM_FIELDS-1:0] sel);
    field_t result;
    result = '0;
    for (int j = 0; j < NUM_FIELDS; j++) begin
      if (sel[j]) begin
        result = result | pkt.field[j];
      end
    end
    return result;
  endfunction

  packet_t            routed_pkt;
  packet_t            operand_pkt;
  logic               s1_valid;
  packet_t            s1_org;
  packet_t            s1_ops;
  logic [FIELD_W-1:0] offset_shifted;

  // The incoming strobe counts too, so no config swap lands on an accept edge
  assign busy = data_valid | s1_valid | kernel_valid;

  // --------------------------------------------------------------------
  // Stage 1: routing and constant substitution
  // --------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      routed_pkt.field[i] = route_field(data_in, active_cfg.ops_mask[i]);
      if (active_cfg.const_mask[i]) begin
        operand_pkt.field[i] = active_cfg.const_value;
      end else begin
        operand_pkt.field[i] = routed_pkt.field[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      s1_valid <= 1'b0;
    end else begin
      // Packets with no active configuration are dropped here
      s1_valid <= data_valid & cfg_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (data_valid) begin
      s1_org <= routed_pkt;
      s1_ops <= operand_pkt;
    end
  end

  // --------------------------------------------------------------------
  // Stage 2: offset from operand field 1
  // --------------------------------------------------------------------
  always_comb begin
    if (active_cfg.direction) begin
      offset_shifted = s1_ops.field[1] << active_cfg.granularity;
    end else begin
      offset_shifted = s1_ops.field[1] >> active_cfg.granularity;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      kernel_valid <= 1'b0;
    end else begin
      kernel_valid <= s1_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (s1_valid) begin
      kernel_addr.base         <= active_cfg.array_pointer;
      kernel_addr.offset       <= addr_t'(offset_shifted);
      kernel_addr.shift_amount <= active_cfg.granularity;
      kernel_addr.direction    <= active_cfg.direction;
      kernel_data              <= s1_org;
    end
  end

  // Routing rows must be one-hot or empty once a configuration is live
  for (genvar g = 0; g < NUM_FIELDS; g++) begin : g_mask_check
    assert property (@(posedge ap_clk) disable iff (areset)
      cfg_valid |-> $onehot0(active_cfg.ops_mask[g]))
      else $error("ops_mask row %0d is not one-hot", g);
  end

endmodule : rw_field_select_kernel

/* rw_config_regs.sv */
// Shadow and active configuration registers with apply-when-idle transfer

`timescale 1ns/100ps

module rw_config_regs import rw_engine_pkg::*; (
  input  logic       ap_clk,
  input  logic       areset,
  input  logic       clear,
  input  logic       cfg_write,
  input  rw_config_t cfg_in,
  input  logic       busy,
  output rw_config_t active_cfg,
  output logic       cfg_valid
);

  rw_config_t shadow_cfg;
  logic       pending;
  logic       apply_cfg;

  // Move the shadow over only while nothing is in flight
  assign apply_cfg = pending & ~busy;

  // --------------------------------------------------------------------
  // Control state
  // --------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      pending   <= 1'b0;
      cfg_valid <= 1'b0;
    end else begin
      // A write on the apply edge keeps the newer value pending
      if (cfg_write) begin
        pending <= 1'b1;
      end else if (apply_cfg) begin
        pending <= 1'b0;
      end
      if (apply_cfg) begin
        cfg_valid <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // Configuration payload
  // --------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (cfg_write) begin
      shadow_cfg <= cfg_in;
    end
    if (apply_cfg) begin
      active_cfg <= shadow_cfg;
    end
  end

  // One packet must see one configuration from entry to request
  assert property (@(posedge ap_clk) disable iff (areset)
    busy |=> $stable(active_cfg))
    else $error("active_cfg changed while a packet was in flight");

endmodule : rw_config_regs

/* rw_engine_pkg.sv */
// Widths, field typedefs, packet, configuration, address and request structs, command enum

package rw_engine_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------
  localparam int NUM_FIELDS = 4;
  localparam int FIELD_W    = 32;
  localparam int ADDR_W     = 32;
  localparam int SHIFT_W    = 5;

  // --------------------------------------------------------------------
  // Scalar types
  // --------------------------------------------------------------------
  typedef logic [FIELD_W-1:0] field_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [SHIFT_W-1:0] shift_t;

  // Memory command carried with each request
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } rw_cmd_e;

  // --------------------------------------------------------------------
  // Structs
  // --------------------------------------------------------------------

  // Field 0 sits in the low bits
  typedef struct packed {
    field_t [NUM_FIELDS-1:0] field;
  } packet_t;

  // Row i of ops_mask picks the input field for output field i
  typedef struct packed {
    logic [NUM_FIELDS-1:0]                  const_mask;
    field_t                                 const_value;
    logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0]  ops_mask;
    shift_t                                 granularity;
    logic                                   direction;     // 1 shifts left
    addr_t                                  array_pointer;
    rw_cmd_e                                command;
  } rw_config_t;

  typedef struct packed {
    addr_t  base;
    addr_t  offset;
    shift_t shift_amount;
    logic   direction;
  } mem_address_t;

  typedef struct packed {
    rw_cmd_e command;
    addr_t   address;
    packet_t data;
  } mem_request_t;

endpackage : rw_engine_pkg
